/* src.f */
+incdir+src
src/execPkg.sv
src/decodeCtrl.sv
src/aluUnit.sv
src/shiftCounter.sv
src/shiftSequencer.sv
src/creditQueue.sv
src/execUnit.sv
tb/execUnitTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = execUnitTb
FILELIST = src.f
OUTDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OUTDIR)
	@out="$$(./$(OUTDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OUTDIR)

/* tb/execUnitTb.sv */
`timescale 1ns/10ps
`include "exec_config.svh"

module execUnitTb;

    localparam int numReqs = 400;
    localparam int stallLimit = 1000;
    localparam int drainLimit = 5000;
    localparam int holdStart = 150;
    localparam int holdEnd = 550;

    logic clk;
    logic rstN;
    logic reqValid;
    execPkg::execReq_t reqData;
    logic reqCredit;
    logic resValid;
    execPkg::execRes_t resData;
    logic resCredit;

    execPkg::execRes_t expQ[$];
    logic [31:0] stimState;
    logic [31:0] sinkState;
    int inCredits;
    int outCredits;
    int checked;
    int sinkCycle;

    execUnit i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqData  (reqData),
        .reqCredit(reqCredit),
        .resValid (resValid),
        .resData  (resData),
        .resCredit(resCredit)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        stimState = xorshift(stimState);
        return stimState;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("error: %s got 0x%h expected 0x%h (result %0d)", name, got, want, checked);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // builds a legal RV32I word from one of the nine classes, or an unknown opcode
    function automatic execPkg::execReq_t makeReq();
        execPkg::execReq_t r;
        logic [31:0] w;
        logic [31:0] pick;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] amt;
        w = nextRand();
        r.pc = nextRand();
        r.rs1Val = nextRand();
        r.rs2Val = nextRand();
        if (w[3:0] == 4'd0) r.rs2Val = r.rs1Val;
        pick = nextRand() % 3;
        if (pick == 0) amt = 5'd0;
        else if (pick == 1) amt = 5'd31;
        else amt = w[4:0];
        f3 = w[14:12];
        f7 = w[31:25];
        pick = nextRand() % 10;
        case (pick)
            0: r.instr = {w[31:7], `LUI};
            1: r.instr = {w[31:7], `AUIPC};
            2: r.instr = {w[31:7], `JAL};
            3: r.instr = {w[31:15], 3'b000, w[11:7], `JALR};
            4: begin
                // 010 and 011 are not branch conditions
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                r.instr = {w[31:15], f3, w[11:7], `BRANCH};
            end
            5: r.instr = {w[31:15], f3, w[11:7], `LOAD};
            6: begin
                f3 = {1'b0, w[13], w[12] & !w[13]};
                r.instr = {w[31:15], f3, w[11:7], `STORE};
            end
            7: begin
                if (f3 == 3'b001) f7 = 7'h00;
                else if (f3 == 3'b101) f7 = {1'b0, w[30], 5'd0};
                else if (w[6:5] == 2'b00) f7 = 7'h20;
                r.instr = {f7, w[24:15], f3, w[11:7], `OP_IMM};
                if (f3[1:0] == 2'b01) r.instr[24:20] = amt;
            end
            8: begin
                f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, w[30], 5'd0} : 7'h00;
                r.instr = {f7, w[24:15], f3, w[11:7], `OP};
                if (f3[1:0] == 2'b01) r.rs2Val[4:0] = amt;
            end
            default: r.instr = {w[31:7], 7'b0001111};
        endcase
        return r;
    endfunction

    function automatic execPkg::execRes_t refResult(input execPkg::execReq_t r);
        execPkg::execRes_t e;
        logic [31:0] i;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] b;
        logic [4:0] sh;
        logic taken;
        i = r.instr;
        immI = {{20{i[31]}}, i[31:20]};
        immS = {{20{i[31]}}, i[31:25], i[11:7]};
        immB = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        immU = {i[31:12], 12'd0};
        immJ = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        e = '0;
        e.nextPc = r.pc + 32'd4;
        case (i[6:0])
            `LUI: begin
                e.result = immU;
                e.regWrite = 1'b1;
            end
            `AUIPC: begin
                e.result = r.pc + immU;
                e.regWrite = 1'b1;
            end
            `JAL, `JALR: begin
                e.result = r.pc + 32'd4;
                e.regWrite = 1'b1;
                e.branchTaken = 1'b1;
                e.nextPc = (i[6:0] == `JAL) ? r.pc + immJ : (r.rs1Val + immI) & ~32'd1;
            end
            `BRANCH: begin
                case (i[14:12])
                    3'b000: taken = (r.rs1Val == r.rs2Val);
                    3'b001: taken = (r.rs1Val != r.rs2Val);
                    3'b100: taken = ($signed(r.rs1Val) < $signed(r.rs2Val));
                    3'b101: taken = ($signed(r.rs1Val) >= $signed(r.rs2Val));
                    3'b110: taken = (r.rs1Val < r.rs2Val);
                    default: taken = (r.rs1Val >= r.rs2Val);
                endcase
                e.branchTaken = taken;
                if (taken) e.nextPc = r.pc + immB;
            end
            `LOAD: begin
                e.result = r.rs1Val + immI;
                e.regWrite = 1'b1;
                e.memRead = 1'b1;
                e.memToReg = 1'b1;
            end
            `STORE: begin
                e.result = r.rs1Val + immS;
                if (i[14:12] == 3'b000) e.memWrite = execPkg::writeByte;
                else if (i[14:12] == 3'b001) e.memWrite = execPkg::writeHalf;
                else e.memWrite = execPkg::writeWord;
            end
            `OP, `OP_IMM: begin
                b = (i[6:0] == `OP) ? r.rs2Val : immI;
                sh = b[4:0];
                e.regWrite = 1'b1;
                case (i[14:12])
                    3'b000: e.result = (i[6:0] == `OP && i[30]) ? r.rs1Val - b : r.rs1Val + b;
                    3'b001: e.result = r.rs1Val << sh;
                    3'b010: e.result = {31'd0, $signed(r.rs1Val) < $signed(b)};
                    3'b011: e.result = {31'd0, r.rs1Val < b};
                    3'b100: e.result = r.rs1Val ^ b;
                    3'b101: begin
                        if (i[30]) begin
                            e.result = $signed(r.rs1Val) >>> sh;
                        end else begin
                            e.result = r.rs1Val >> sh;
                        end
                    end
                    3'b110: e.result = r.rs1Val | b;
                    default: e.result = r.rs1Val & b;
                endcase
            end
            default: e = '{result: '0, nextPc: r.pc + 32'd4, memWrite: execPkg::writeIdle,
                           default: 1'b0};
        endcase
        return e;
    endfunction

    // every pulse of reqCredit hands one queue slot back to the sender
    always @(negedge clk) begin
        if (rstN && reqCredit) begin
            inCredits = inCredits + 1;
            if (inCredits > `QUEUE_DEPTH) failRun("queue returned more credits than it holds");
        end
    end

    always @(negedge clk) begin : compare
        execPkg::execRes_t want;
        if (rstN && resValid) begin
            if (outCredits == 0) failRun("result sent while no output credit was held");
            outCredits = outCredits - 1;
            if (expQ.size() == 0) failRun("result arrived with no request outstanding");
            want = expQ.pop_front();
            checkField("result", resData.result, want.result);
            checkField("nextPc", resData.nextPc, want.nextPc);
            checkField("regWrite", 32'(resData.regWrite), 32'(want.regWrite));
            checkField("memRead", 32'(resData.memRead), 32'(want.memRead));
            checkField("memToReg", 32'(resData.memToReg), 32'(want.memToReg));
            checkField("memWrite", 32'(resData.memWrite), 32'(want.memWrite));
            checkField("branchTaken", 32'(resData.branchTaken), 32'(want.branchTaken));
            checked = checked + 1;
        end
    end

    // the sink withholds all credits for a long stretch, then returns them at random gaps
    initial begin
        resCredit = 1'b0;
        sinkState = xorshift(32'hc3d8);
        sinkCycle = 0;
        forever begin
            @(posedge clk);
            #2;
            resCredit = 1'b0;
            sinkState = xorshift(sinkState);
            if (rstN) sinkCycle = sinkCycle + 1;
            if (rstN && (sinkCycle < holdStart || sinkCycle >= holdEnd) &&
                    outCredits < `OUT_CREDITS && sinkState[1:0] == 2'b00) begin
                resCredit = 1'b1;
                outCredits = outCredits + 1;
            end
        end
    end

    initial begin : sender
        int sent;
        int stall;
        int waited;
        clk = 1'b0;
        rstN = 1'b0;
        reqValid = 1'b0;
        reqData = '0;
        stimState = 32'hc3d8;
        inCredits = `QUEUE_DEPTH;
        outCredits = `OUT_CREDITS;
        checked = 0;
        sent = 0;
        stall = 0;
        waited = 0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        while (sent < numReqs) begin
            @(posedge clk);
            #2;
            if (inCredits > 0) begin
                reqData = makeReq();
                reqValid = 1'b1;
                expQ.push_back(refResult(reqData));
                inCredits = inCredits - 1;
                sent = sent + 1;
                stall = 0;
            end else begin
                reqValid = 1'b0;
                stall = stall + 1;
                if (stall > stallLimit) failRun("sender starved of input credits");
            end
        end
        @(posedge clk);
        #2;
        reqValid = 1'b0;
        while (expQ.size() != 0 || inCredits != `QUEUE_DEPTH) begin
            @(posedge clk);
            waited = waited + 1;
            if (waited > drainLimit) failRun("outstanding requests never completed");
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* src/execUnit.sv */
`timescale 1ns/10ps

module execUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              reqValid,
    input  execPkg::execReq_t reqData,
    output logic              reqCredit,
    output logic              resValid,
    output execPkg::execRes_t resData,
    input  logic              resCredit
);

    execPkg::execReq_t headReq;
    execPkg::ctrl_t ctrl;
    execPkg::execRes_t pre;
    logic empty;
    logic pop;
    logic isShift;

    creditQueue i_queue (
        .clk     (clk),
        .rstN    (rstN),
        .push    (reqValid),
        .pushData(reqData),
        .pop     (pop),
        .headReq (headReq),
        .empty   (empty),
        .credit  (reqCredit)
    );

    decodeCtrl i_decode (
        .instr(headReq.instr),
        .ctrl (ctrl)
    );

    aluUnit i_alu (
        .req    (headReq),
        .ctrl   (ctrl),
        .res    (pre),
        .isShift(isShift)
    );

    // the head's source value is the shift operand
    shiftSequencer i_sequencer (
        .clk      (clk),
        .rstN     (rstN),
        .empty    (empty),
        .pre      (pre),
        .isShift  (isShift),
        .shiftOp  (ctrl.aluOp),
        .shiftIn  (headReq.rs1Val),
        .pop      (pop),
        .resCredit(resCredit),
        .resValid (resValid),
        .resData  (resData)
    );

endmodule

/* src/creditQueue.sv */
`timescale 1ns/10ps
`include "exec_config.svh"

module creditQueue (
    input  logic              clk,
    input  logic              rstN,
    input  logic              push,
    input  execPkg::execReq_t pushData,
    input  logic              pop,
    output execPkg::execReq_t headReq,
    output logic              empty,
    output logic              credit
);

    localparam int depth   = `QUEUE_DEPTH;
    localparam int ptrBits = $clog2(depth);

    execPkg::execReq_t mem [depth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0] count;
    logic full;

    assign empty   = (count == '0);
    assign full    = (count == (ptrBits + 1)'(depth));
    assign headReq = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop) rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // every popped entry hands one credit back to the producer
            credit <= pop;
        end
    end

    // a producer that honours its credits never finds the queue full
    pushWhenFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("request pushed into a full queue");

endmodule

/* src/shiftSequencer.sv */
`timescale 1ns/10ps
`include "exec_config.svh"

module shiftSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              empty,
    input  execPkg::execRes_t pre,
    input  logic              isShift,
    input  execPkg::aluOp_t   shiftOp,
    input  execPkg::word_t    shiftIn,
    output logic              pop,
    input  logic              resCredit,
    output logic              resValid,
    output execPkg::execRes_t resData
);

    localparam int creditBits = $clog2(`OUT_CREDITS + 1);

    typedef enum logic [1:0] {sIdle, sShift, sSend} state_t;

    state_t state;
    execPkg::execRes_t held;
    execPkg::aluOp_t heldOp;
    execPkg::word_t shifted;
    logic [creditBits-1:0] credits;
    logic [4:0] preAmount;
    logic load;
    logic [4:0] amount;
    logic done;

    // a zero shift needs no serial steps and goes straight to sSend
    assign preAmount = pre.result[4:0];
    assign pop       = (state == sIdle) && !empty;
    assign load      = pop && isShift && (preAmount != 5'd0);
    assign amount    = preAmount - 5'd1;
    assign resValid  = (state == sSend) && (credits != '0);
    assign resData   = held;

    shiftCounter i_shiftCounter (
        .clk   (clk),
        .rstN  (rstN),
        .load  (load),
        .amount(amount),
        .done  (done)
    );

    always_comb begin
        case (heldOp)
            execPkg::opSll: shifted = {held.result[30:0], 1'b0};
            execPkg::opSrl: shifted = {1'b0, held.result[31:1]};
            execPkg::opSra: shifted = {held.result[31], held.result[31:1]};
            default:        shifted = held.result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle:   if (pop) state <= load ? sShift : sSend;
                sShift:  if (done) state <= sSend;
                sSend:   if (resValid) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            held   <= pre;
            heldOp <= shiftOp;
            if (isShift) begin
                held.result <= shiftIn;
            end
        end else if (state == sShift) begin
            held.result <= shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            credits <= creditBits'(`OUT_CREDITS);
        end else begin
            case ({resCredit, resValid})
                2'b10:   if (credits != creditBits'(`OUT_CREDITS)) credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // the consumer can never hand back more credits than it was granted
    creditOverflow: assert property (@(posedge clk) disable iff (!rstN)
        resCredit && !resValid |-> credits < creditBits'(`OUT_CREDITS))
        else $error("result credit returned with %0d credits already held", credits);

endmodule

/* src/shiftCounter.sv */
`timescale 1ns/10ps

module shiftCounter (
    input  logic       clk,
    input  logic       rstN,
    input  logic       load,
    input  logic [4:0] amount,
    output logic       done
);

    logic [4:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= amount;
        end else if (count != 5'd0) begin
            count <= count - 5'd1;
        end
    end

    assign done = (count == 5'd0);

    // the sequencer may only start a new shift once the previous one has drained
    loadWhileBusy: assert property (@(posedge clk) disable iff (!rstN) load |-> done)
        else $error("shift counter reloaded with %0d cycles left", count);

endmodule

/* src/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
    input  execPkg::execReq_t req,
    input  execPkg::ctrl_t    ctrl,
    output execPkg::execRes_t res,
    output logic              isShift
);

    execPkg::word_t opB;
    execPkg::word_t aluOut;
    execPkg::word_t pcPlus4;
    execPkg::word_t pcPlusImm;
    execPkg::word_t jumpTarget;
    logic cond;

    assign opB        = ctrl.aluSrc ? ctrl.imm : req.rs2Val;
    assign pcPlus4    = req.pc + 32'd4;
    assign pcPlusImm  = req.pc + ctrl.imm;
    assign jumpTarget = (req.rs1Val + ctrl.imm) & ~32'd1;

    always_comb begin
        cond   = 1'b0;
        aluOut = '0;
        case (ctrl.aluOp)
            execPkg::opAdd:  aluOut = req.rs1Val + opB;
            execPkg::opSub:  aluOut = req.rs1Val - opB;
            execPkg::opSlt:  aluOut = {31'd0, $signed(req.rs1Val) < $signed(opB)};
            execPkg::opSltu: aluOut = {31'd0, req.rs1Val < opB};
            execPkg::opXor:  aluOut = req.rs1Val ^ opB;
            execPkg::opOr:   aluOut = req.rs1Val | opB;
            execPkg::opAnd:  aluOut = req.rs1Val & opB;
            execPkg::opLui:  aluOut = ctrl.imm;
            execPkg::opBeq:  cond = (req.rs1Val == opB);
            execPkg::opBne:  cond = (req.rs1Val != opB);
            execPkg::opBlt:  cond = ($signed(req.rs1Val) < $signed(opB));
            execPkg::opBge:  cond = ($signed(req.rs1Val) >= $signed(opB));
            execPkg::opBltu: cond = (req.rs1Val < opB);
            execPkg::opBgeu: cond = (req.rs1Val >= opB);
            // shifts carry their amount to the sequencer in the low bits
            execPkg::opSll, execPkg::opSrl, execPkg::opSra: aluOut = opB;
            default:         aluOut = '0;
        endcase
    end

    always_comb begin
        res = '0;
        if (ctrl.jump || ctrl.jumpReg) begin
            res.result = pcPlus4;
        end else if (ctrl.pcSrc) begin
            res.result = pcPlusImm;
        end else begin
            res.result = aluOut;
        end
        if (ctrl.jumpReg) begin
            res.nextPc = jumpTarget;
        end else if ((ctrl.branch && cond) || ctrl.jump) begin
            res.nextPc = pcPlusImm;
        end else begin
            res.nextPc = pcPlus4;
        end
        res.regWrite    = ctrl.regWrite;
        res.memRead     = ctrl.memRead;
        res.memToReg    = ctrl.memToReg;
        res.memWrite    = ctrl.memWrite;
        res.branchTaken = (ctrl.branch && cond) || ctrl.jump || ctrl.jumpReg;
    end

    assign isShift = ctrl.aluOp inside {execPkg::opSll, execPkg::opSrl, execPkg::opSra};

endmodule

/* src/decodeCtrl.sv */
`timescale 1ns/10ps
`include "exec_config.svh"

module decodeCtrl (
    input  execPkg::word_t instr,
    output execPkg::ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    // {branch, memRead, memToReg, aluSrc, regWrite, pcSrc}
    logic [5:0] flags;
    execPkg::aluOp_t aluOp;
    execPkg::memWidth_t memWrite;
    execPkg::word_t imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        case (opcode)
            `LUI:    flags = 6'b000110;
            `AUIPC:  flags = 6'b000111;
            `JAL:    flags = 6'b100110;
            `JALR:   flags = 6'b100110;
            `BRANCH: flags = 6'b100000;
            `LOAD:   flags = 6'b011110;
            `STORE:  flags = 6'b000100;
            `OP_IMM: flags = 6'b000110;
            `OP:     flags = 6'b000010;
            default: flags = 6'b000000;
        endcase
    end

    always_comb begin
        aluOp = execPkg::opIdle;
        case (opcode)
            `LUI:   aluOp = execPkg::opLui;
            `JALR:  aluOp = execPkg::opAdd;
            `LOAD:  aluOp = execPkg::opAdd;
            `STORE: aluOp = execPkg::opAdd;
            `BRANCH: begin
                case (funct3)
                    3'b000:  aluOp = execPkg::opBeq;
                    3'b001:  aluOp = execPkg::opBne;
                    3'b100:  aluOp = execPkg::opBlt;
                    3'b101:  aluOp = execPkg::opBge;
                    3'b110:  aluOp = execPkg::opBltu;
                    3'b111:  aluOp = execPkg::opBgeu;
                    default: aluOp = execPkg::opIdle;
                endcase
            end
            `OP_IMM, `OP: begin
                case (funct3)
                    3'b000:  aluOp = execPkg::opAdd;
                    3'b001:  aluOp = execPkg::opSll;
                    3'b010:  aluOp = execPkg::opSlt;
                    3'b011:  aluOp = execPkg::opSltu;
                    3'b100:  aluOp = execPkg::opXor;
                    3'b101:  aluOp = execPkg::opSrl;
                    3'b110:  aluOp = execPkg::opOr;
                    default: aluOp = execPkg::opAnd;
                endcase
                // register ops and immediate shifts carry funct7, which picks SUB and SRA
                if (opcode == `OP || funct3[1:0] == 2'b01) begin
                    if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                        aluOp = execPkg::opSra;
                    end else if (funct7 == 7'b0100000 && funct3 == 3'b000 && opcode == `OP) begin
                        aluOp = execPkg::opSub;
                    end else if (funct7 != 7'b0000000) begin
                        aluOp = execPkg::opIdle;
                    end
                end
            end
            default: aluOp = execPkg::opIdle;
        endcase
    end

    always_comb begin
        memWrite = execPkg::writeIdle;
        if (opcode == `STORE) begin
            case (funct3)
                3'b000:  memWrite = execPkg::writeByte;
                3'b001:  memWrite = execPkg::writeHalf;
                3'b010:  memWrite = execPkg::writeWord;
                default: memWrite = execPkg::writeIdle;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            `LUI, `AUIPC:         imm = {instr[31:12], 12'd0};
            `JAL:                 imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                         instr[30:21], 1'b0};
            `BRANCH:              imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                         instr[11:8], 1'b0};
            `STORE:               imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `JALR, `LOAD, `OP_IMM: imm = {{20{instr[31]}}, instr[31:20]};
            default:              imm = '0;
        endcase
    end

    assign ctrl = '{branch: flags[5], memRead: flags[4], memToReg: flags[3],
                    memWrite: memWrite, aluSrc: flags[2], regWrite: flags[1],
                    pcSrc: flags[0], jump: (opcode == `JAL), jumpReg: (opcode == `JALR),
                    aluOp: aluOp, imm: imm};

endmodule

/* src/execPkg.sv */
package execPkg;

    typedef logic [31:0] word_t;

    typedef enum logic [4:0] {
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd,
        opLui, opBeq, opBne, opBlt, opBge, opBltu, opBgeu, opIdle
    } aluOp_t;

    typedef enum logic [1:0] {writeIdle, writeByte, writeHalf, writeWord} memWidth_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t rs1Val;
        word_t rs2Val;
    } execReq_t;

    typedef struct packed {
        logic      branch;
        logic      memRead;
        logic      memToReg;
        memWidth_t memWrite;
        logic      aluSrc;
        logic      regWrite;
        logic      pcSrc;
        logic      jump;
        logic      jumpReg;
        aluOp_t    aluOp;
        word_t     imm;
    } ctrl_t;

    // branchTaken is set whenever the pc leaves the fall-through path
    typedef struct packed {
        word_t     result;
        word_t     nextPc;
        logic      regWrite;
        logic      memRead;
        logic      memToReg;
        memWidth_t memWrite;
        logic      branchTaken;
    } execRes_t;

endpackage

/* src/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// RV32I base opcodes handled by the slice
`define LUI     7'b0110111
`define AUIPC   7'b0010111
`define JAL     7'b1101111
`define JALR    7'b1100111
`define BRANCH  7'b1100011
`define LOAD    7'b0000011
`define STORE   7'b0100011
`define OP_IMM  7'b0010011
`define OP      7'b0110011

// entries in the request queue, equal to the producer's starting credits
`define QUEUE_DEPTH 4

// result credits the consumer grants after reset
`define OUT_CREDITS 2

`endif
